// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Major opcodes, every other code decodes as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_XOR  = 4'h3,
        OP_ADDI = 4'h4,
        OP_MUL  = 4'h5
    } opcode_e;

    // ALU function select
    typedef enum logic [1:0] {
        ALU_ADD  = 2'd0,
        ALU_SUB  = 2'd1,
        ALU_XOR  = 2'd2,
        ALU_ADDI = 2'd3
    } alu_op_e;

    // Fixed 16-bit format, rs2 doubles as the ADDI immediate
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
    } inst_t;

endpackage

`default_nettype wire

// ==== verilog/uarch_pkg.sv ====
`default_nettype none

package uarch_pkg;

    localparam int unsigned XLEN      = 32;
    localparam int unsigned ARCH_REGS = 16;
    localparam int unsigned PHYS_REGS = 32;
    localparam int unsigned ROB_DEPTH = 8;
    // Wide enough for the largest supported ROB
    localparam int unsigned ROB_IDX_W = 6;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] prf_idx_t;
    typedef logic [ROB_IDX_W-1:0]         rob_idx_t;
    typedef logic [XLEN-1:0]              xlen_t;

    typedef struct packed {
        logic             is_mul;
        isa_pkg::alu_op_e alu_op;
        logic             rd_wen;
        prf_idx_t         prs1;
        prf_idx_t         prs2;
        logic [3:0]       imm;
        prf_idx_t         prd;
        rob_idx_t         rob_idx;
    } uop_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        xlen_t    value;
    } wb_t;

    typedef struct packed {
        logic      valid;
        logic      ready;
        logic      rd_wen;
        arch_idx_t rd_arch;
        prf_idx_t  new_prf;
        prf_idx_t  old_prf;
        xlen_t     value;
    } rob_entry_t;

    typedef struct packed {
        logic      valid;
        logic      rd_wen;
        arch_idx_t rd_arch;
        prf_idx_t  new_prf;
        prf_idx_t  old_prf;
    } disp_t;

    typedef struct packed {
        logic      valid;
        logic      rd_wen;
        arch_idx_t rd_arch;
        prf_idx_t  old_prf;
        xlen_t     value;
    } commit_t;

endpackage

`default_nettype wire

// ==== verilog/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  logic                clock,
    input  logic                reset,
    input  logic                pop_i,
    input  logic                push_i,
    input  uarch_pkg::prf_idx_t push_tag_i,
    output uarch_pkg::prf_idx_t tag_o,
    output logic                empty_o
);
    import uarch_pkg::*;

    localparam int unsigned SLOTS = PHYS_REGS - ARCH_REGS;
    localparam int unsigned PTR_W = $clog2(SLOTS);

    prf_idx_t         slots_q [SLOTS];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;

    assign tag_o   = slots_q[rd_ptr_q];
    assign empty_o = (count_q == '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // Every tag above the identity mapping starts out free
            for (int i = 0; i < SLOTS; i++) begin
                slots_q[i] <= prf_idx_t'(ARCH_REGS + i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= (PTR_W+1)'(SLOTS);
        end else begin
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_i) begin
                slots_q[wr_ptr_q] <= push_tag_i;
                wr_ptr_q          <= wr_ptr_q + 1'b1;
            end
            count_q <= count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_i);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_decode #(
    parameter int unsigned DEPTH = uarch_pkg::ROB_DEPTH
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     inst_valid_i,
    input  isa_pkg::inst_t           inst_i,
    output logic                     inst_ready_o,
    input  uarch_pkg::prf_idx_t      free_tag_i,
    input  logic                     free_empty_i,
    output logic                     free_pop_o,
    input  logic [$clog2(DEPTH)-1:0] alloc_idx_i,
    input  logic                     credit_return_i,
    output uarch_pkg::disp_t         disp_o,
    output logic                     uop_valid_o,
    output uarch_pkg::uop_t          uop_o,
    input  logic                     exec_ready_i
);
    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    prf_idx_t         rat_q [ARCH_REGS];
    logic [CNT_W-1:0] credits_q;
    logic             is_mul;
    alu_op_e          alu_op;
    logic             rd_wen;
    logic             out_free;
    logic             accept;
    uop_t             uop_q;
    logic             uop_valid_q;

    always_comb begin
        is_mul = 1'b0;
        alu_op = ALU_ADD;
        rd_wen = 1'b1;
        case (inst_i.opcode)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_XOR:  alu_op = ALU_XOR;
            OP_ADDI: alu_op = ALU_ADDI;
            OP_MUL:  is_mul = 1'b1;
            // NOP and undefined codes travel as an ALU op with no result
            default: rd_wen = 1'b0;
        endcase
    end

    // Output register is free when empty or handing over this cycle
    assign out_free     = !uop_valid_q || exec_ready_i;
    assign inst_ready_o = (credits_q != '0) && (!rd_wen || !free_empty_i) && out_free;
    assign accept       = inst_valid_i && inst_ready_o;
    assign free_pop_o   = accept && rd_wen;

    // ROB allocation goes together with the rename
    assign disp_o.valid   = accept;
    assign disp_o.rd_wen  = rd_wen;
    assign disp_o.rd_arch = inst_i.rd;
    assign disp_o.new_prf = free_tag_i;
    assign disp_o.old_prf = rat_q[inst_i.rd];

    assign uop_valid_o = uop_valid_q;
    assign uop_o       = uop_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // Identity mapping
            for (int r = 0; r < ARCH_REGS; r++) begin
                rat_q[r] <= prf_idx_t'(r);
            end
            credits_q   <= CNT_W'(DEPTH);
            uop_valid_q <= 1'b0;
        end else begin
            if (free_pop_o) begin
                rat_q[inst_i.rd] <= free_tag_i;
            end
            credits_q <= credits_q - CNT_W'(accept) + CNT_W'(credit_return_i);
            if (accept) begin
                uop_valid_q <= 1'b1;
            end else if (exec_ready_i) begin
                uop_valid_q <= 1'b0;
            end
        end
    end

    // Sources read the table before this cycle's rename lands
    always_ff @(posedge clock) begin
        if (accept) begin
            uop_q.is_mul  <= is_mul;
            uop_q.alu_op  <= alu_op;
            uop_q.rd_wen  <= rd_wen;
            uop_q.prs1    <= rat_q[inst_i.rs1];
            uop_q.prs2    <= rat_q[inst_i.rs2];
            uop_q.imm     <= inst_i.rs2;
            uop_q.prd     <= free_tag_i;
            uop_q.rob_idx <= rob_idx_t'(alloc_idx_i);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic            clock,
    input  logic            reset,
    input  logic            uop_valid_i,
    input  uarch_pkg::uop_t uop_i,
    output logic            ready_o,
    output uarch_pkg::wb_t  alu_wb_o,
    output uarch_pkg::wb_t  mul_wb_o
);
    import isa_pkg::*;
    import uarch_pkg::*;

    // Destination carried beside each result
    typedef struct packed {
        logic     valid;
        logic     wen;
        prf_idx_t prd;
        rob_idx_t rob_idx;
    } tag_t;

    xlen_t                prf_q [PHYS_REGS];
    logic [PHYS_REGS-1:0] busy_q;
    logic                 hit1_alu;
    logic                 hit1_mul;
    logic                 hit2_alu;
    logic                 hit2_mul;
    logic                 issue;
    xlen_t                src1;
    xlen_t                src2;
    xlen_t                alu_res;
    tag_t                 alu_tag_q;
    xlen_t                alu_val_q;
    tag_t                 mul_tag_q [3];
    xlen_t                mul_a_q;
    xlen_t                mul_b_q;
    xlen_t                mul_p_q;
    xlen_t                mul_val_q;

    // Forwarding from the writeback stage only
    assign hit1_alu = alu_tag_q.valid && alu_tag_q.wen && (alu_tag_q.prd == uop_i.prs1);
    assign hit1_mul = mul_tag_q[2].valid && mul_tag_q[2].wen && (mul_tag_q[2].prd == uop_i.prs1);
    assign hit2_alu = alu_tag_q.valid && alu_tag_q.wen && (alu_tag_q.prd == uop_i.prs2);
    assign hit2_mul = mul_tag_q[2].valid && mul_tag_q[2].wen && (mul_tag_q[2].prd == uop_i.prs2);

    assign src1 = hit1_alu ? alu_val_q : (hit1_mul ? mul_val_q : prf_q[uop_i.prs1]);
    assign src2 = hit2_alu ? alu_val_q : (hit2_mul ? mul_val_q : prf_q[uop_i.prs2]);

    assign ready_o = (!busy_q[uop_i.prs1] || hit1_alu || hit1_mul)
                  && (!busy_q[uop_i.prs2] || hit2_alu || hit2_mul);
    assign issue   = uop_valid_i && ready_o;

    always_comb begin
        case (uop_i.alu_op)
            ALU_SUB:  alu_res = src1 - src2;
            ALU_XOR:  alu_res = src1 ^ src2;
            ALU_ADDI: alu_res = src1 + xlen_t'(uop_i.imm);
            default:  alu_res = src1 + src2;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int p = 0; p < PHYS_REGS; p++) begin
                prf_q[p] <= '0;
            end
            busy_q    <= '0;
            alu_tag_q <= '0;
            for (int s = 0; s < 3; s++) begin
                mul_tag_q[s] <= '0;
            end
        end else begin
            // Results land in the register file and release their tags
            if (alu_tag_q.valid && alu_tag_q.wen) begin
                prf_q[alu_tag_q.prd]  <= alu_val_q;
                busy_q[alu_tag_q.prd] <= 1'b0;
            end
            if (mul_tag_q[2].valid && mul_tag_q[2].wen) begin
                prf_q[mul_tag_q[2].prd]  <= mul_val_q;
                busy_q[mul_tag_q[2].prd] <= 1'b0;
            end
            if (issue && uop_i.rd_wen) begin
                busy_q[uop_i.prd] <= 1'b1;
            end
            alu_tag_q    <= '{issue && !uop_i.is_mul, uop_i.rd_wen, uop_i.prd, uop_i.rob_idx};
            mul_tag_q[0] <= '{issue && uop_i.is_mul, uop_i.rd_wen, uop_i.prd, uop_i.rob_idx};
            mul_tag_q[1] <= mul_tag_q[0];
            mul_tag_q[2] <= mul_tag_q[1];
        end
    end

    // Operands, product, then result; low XLEN bits of the product
    always_ff @(posedge clock) begin
        alu_val_q <= alu_res;
        mul_a_q   <= src1;
        mul_b_q   <= src2;
        mul_p_q   <= mul_a_q * mul_b_q;
        mul_val_q <= mul_p_q;
    end

    assign alu_wb_o.valid   = alu_tag_q.valid;
    assign alu_wb_o.rob_idx = alu_tag_q.rob_idx;
    assign alu_wb_o.value   = alu_val_q;
    assign mul_wb_o.valid   = mul_tag_q[2].valid;
    assign mul_wb_o.rob_idx = mul_tag_q[2].rob_idx;
    assign mul_wb_o.value   = mul_val_q;

endmodule

`default_nettype wire

// ==== verilog/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int unsigned DEPTH = uarch_pkg::ROB_DEPTH
) (
    input  logic                     clock,
    input  logic                     reset,
    input  uarch_pkg::disp_t         disp_i,
    output logic [$clog2(DEPTH)-1:0] alloc_idx_o,
    input  uarch_pkg::wb_t           alu_wb_i,
    input  uarch_pkg::wb_t           mul_wb_i,
    output uarch_pkg::commit_t       commit_o,
    output logic                     credit_return_o
);
    import uarch_pkg::*;

    localparam int unsigned IDX_W = $clog2(DEPTH);

    rob_entry_t       entries_q [DEPTH];
    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [IDX_W-1:0] alu_idx;
    logic [IDX_W-1:0] mul_idx;
    logic             retire;
    commit_t          commit_q;

    // Next free slot is always the tail
    assign alloc_idx_o = tail_q;

    assign alu_idx = alu_wb_i.rob_idx[IDX_W-1:0];
    assign mul_idx = mul_wb_i.rob_idx[IDX_W-1:0];

    // Oldest entry leaves once its result is in
    assign retire = entries_q[head_q].valid && entries_q[head_q].ready;

    assign commit_o        = commit_q;
    assign credit_return_o = commit_q.valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q   <= '0;
            tail_q   <= '0;
            commit_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries_q[i] <= '0;
            end
        end else begin
            // Decode only dispatches with a credit in hand, so no full check
            if (disp_i.valid) begin
                entries_q[tail_q].valid   <= 1'b1;
                entries_q[tail_q].ready   <= 1'b0;
                entries_q[tail_q].rd_wen  <= disp_i.rd_wen;
                entries_q[tail_q].rd_arch <= disp_i.rd_arch;
                entries_q[tail_q].new_prf <= disp_i.new_prf;
                entries_q[tail_q].old_prf <= disp_i.old_prf;
                tail_q                    <= tail_q + 1'b1;
            end

            // Lanes finish out of order
            if (alu_wb_i.valid) begin
                entries_q[alu_idx].ready <= 1'b1;
                entries_q[alu_idx].value <= alu_wb_i.value;
            end
            if (mul_wb_i.valid) begin
                entries_q[mul_idx].ready <= 1'b1;
                entries_q[mul_idx].value <= mul_wb_i.value;
            end

            commit_q.valid <= retire;
            if (retire) begin
                commit_q.rd_wen         <= entries_q[head_q].rd_wen;
                commit_q.rd_arch        <= entries_q[head_q].rd_arch;
                commit_q.old_prf        <= entries_q[head_q].old_prf;
                commit_q.value          <= entries_q[head_q].value;
                entries_q[head_q].valid <= 1'b0;
                head_q                  <= head_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ooo_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_backend #(
    parameter int unsigned DEPTH = uarch_pkg::ROB_DEPTH
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               inst_valid_i,
    input  isa_pkg::inst_t     inst_i,
    output logic               inst_ready_o,
    output uarch_pkg::commit_t commit_o
);
    import uarch_pkg::*;

    prf_idx_t                 free_tag;
    logic                     free_empty;
    logic                     free_pop;
    logic [$clog2(DEPTH)-1:0] alloc_idx;
    logic                     credit_return;
    disp_t                    disp;
    logic                     uop_valid;
    uop_t                     uop;
    logic                     exec_ready;
    wb_t                      alu_wb;
    wb_t                      mul_wb;

    // Committed writes hand back the previous mapping
    free_list u_free_list (
        .clock      (clock),
        .reset      (reset),
        .pop_i      (free_pop),
        .push_i     (commit_o.valid && commit_o.rd_wen),
        .push_tag_i (commit_o.old_prf),
        .tag_o      (free_tag),
        .empty_o    (free_empty)
    );

    rename_decode #(
        .DEPTH (DEPTH)
    ) u_rename_decode (
        .clock           (clock),
        .reset           (reset),
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .inst_ready_o    (inst_ready_o),
        .free_tag_i      (free_tag),
        .free_empty_i    (free_empty),
        .free_pop_o      (free_pop),
        .alloc_idx_i     (alloc_idx),
        .credit_return_i (credit_return),
        .disp_o          (disp),
        .uop_valid_o     (uop_valid),
        .uop_o           (uop),
        .exec_ready_i    (exec_ready)
    );

    exec_unit u_exec_unit (
        .clock       (clock),
        .reset       (reset),
        .uop_valid_i (uop_valid),
        .uop_i       (uop),
        .ready_o     (exec_ready),
        .alu_wb_o    (alu_wb),
        .mul_wb_o    (mul_wb)
    );

    rob #(
        .DEPTH (DEPTH)
    ) u_rob (
        .clock           (clock),
        .reset           (reset),
        .disp_i          (disp),
        .alloc_idx_o     (alloc_idx),
        .alu_wb_i        (alu_wb),
        .mul_wb_i        (mul_wb),
        .commit_o        (commit_o),
        .credit_return_o (credit_return)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS = 4
) (
    output logic clock_o
);

    initial begin
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2) clock_o = ~clock_o;
    end

endmodule

`default_nettype wire

// ==== tb/ooo_backend_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_backend_assert (
    input logic               clock,
    input logic               reset,
    input logic               inst_valid_i,
    input isa_pkg::inst_t     inst_i,
    input logic               inst_ready_o,
    input uarch_pkg::commit_t commit_o
);
    // Failures seen so far, polled by the testbench
    int unsigned fail_count = 0;

    // Quiet commit port and open input port while in reset
    reset_quiet: assert property (@(posedge clock) reset |-> !commit_o.valid && inst_ready_o)
        else begin
            fail_count++;
            $error("commit_o.valid high or inst_ready_o low during reset");
        end

    // First cycle out of reset
    first_cycle: assert property (@(posedge clock) $fell(reset) |-> !commit_o.valid && inst_ready_o)
        else begin
            fail_count++;
            $error("commit_o.valid high or inst_ready_o low in the cycle after reset");
        end

    commit_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(commit_o.valid))
        else begin
            fail_count++;
            $error("commit_o.valid is unknown");
        end

    ready_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(inst_ready_o))
        else begin
            fail_count++;
            $error("inst_ready_o is unknown");
        end

    // A stalled instruction stays put until it is taken
    inst_held: assert property (@(posedge clock) disable iff (reset)
        inst_valid_i && !inst_ready_o |=> inst_valid_i && $stable(inst_i))
        else begin
            fail_count++;
            $error("inst_i changed or inst_valid_i dropped while stalled");
        end

endmodule

bind ooo_backend ooo_backend_assert u_assert (
    .clock        (clock),
    .reset        (reset),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .inst_ready_o (inst_ready_o),
    .commit_o     (commit_o)
);

`default_nettype wire

// ==== tb/ooo_backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_backend_tb;
    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int unsigned DEPTH          = 8;
    localparam int unsigned RESET_CYCLES   = 8;
    localparam int unsigned RANDOM_COUNT   = 200;
    localparam int unsigned BURST_LEN      = 12;
    localparam int unsigned TOTAL_INSTS    = RANDOM_COUNT + BURST_LEN + 2;
    localparam int unsigned QUIET_CYCLES   = 4 * DEPTH;
    // Eight cycles per instruction covers a dependent MUL plus an idle slot
    localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_INSTS * 8 + QUIET_CYCLES;

    typedef struct packed {
        logic        rd_wen;
        logic [3:0]  rd_arch;
        logic [4:0]  old_prf;
        logic [31:0] value;
    } expect_t;

    logic        clock;
    logic        reset;
    logic        inst_valid_i;
    inst_t       inst_i;
    logic        inst_ready_o;
    commit_t     commit_o;
    logic [31:0] arch_regs [16];
    logic [4:0]  rat_model [16];
    logic [4:0]  free_model_q [$];
    expect_t     expected_q [$];
    logic [15:0] lfsr_q;
    int unsigned stall_cycles;
    int unsigned cycle_count;

    tb_clock_gen #(.PERIOD_NS (4)) u_clock_gen (.clock_o (clock));

    ooo_backend #(.DEPTH (DEPTH)) UUT (
        .clock        (clock),
        .reset        (reset),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .commit_o     (commit_o)
    );

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("ERROR time=%0t signal=%s got=0x%08h expected=0x%08h", $time, name, got, want);
        $display("TEST FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("time=%0t %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [15:0] take_bits(input int unsigned n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[14:0], lfsr_q[0]};
        end
        return val;
    endfunction

    // Mostly defined ops, one draw in eight lands on an undefined code
    function automatic inst_t random_inst();
        inst_t      inst;
        logic [2:0] sel;
        sel = 3'(take_bits(3));
        if (sel <= 3'd5) begin
            inst.opcode = {1'b0, sel};
        end else if (sel == 3'd6) begin
            inst.opcode = OP_ADDI;
        end else begin
            inst.opcode = {1'b1, 3'(take_bits(3))};
        end
        inst.rd  = 4'(take_bits(4));
        inst.rs1 = 4'(take_bits(4));
        inst.rs2 = 4'(take_bits(4));
        return inst;
    endfunction

    // Architectural meaning of one instruction, in program order
    task automatic apply_model(input inst_t inst);
        expect_t     rec;
        logic [31:0] a;
        logic [31:0] b;
        a           = arch_regs[inst.rs1];
        b           = arch_regs[inst.rs2];
        rec.rd_arch = inst.rd;
        rec.rd_wen  = 1'b1;
        rec.old_prf = rat_model[inst.rd];
        rec.value   = '0;
        case (inst.opcode)
            OP_ADD:  rec.value = a + b;
            OP_SUB:  rec.value = a - b;
            OP_XOR:  rec.value = a ^ b;
            OP_ADDI: rec.value = a + {28'd0, inst.rs2};
            OP_MUL:  rec.value = a * b;
            default: rec.rd_wen = 1'b0;
        endcase
        if (rec.rd_wen) begin
            arch_regs[inst.rd] = rec.value;
            // New mapping comes from the head of the free tag FIFO
            rat_model[inst.rd] = free_model_q.pop_front();
        end
        expected_q.push_back(rec);
    endtask

    // Starts and ends on a falling edge, holds the instruction until taken
    task automatic send_inst(input inst_t inst);
        logic taken;
        inst_valid_i = 1'b1;
        inst_i       = inst;
        taken        = 1'b0;
        while (!taken) begin
            @(posedge clock);
            taken = inst_ready_o;
            if (!taken) begin
                stall_cycles++;
            end
            @(negedge clock);
        end
        inst_valid_i = 1'b0;
        apply_model(inst);
    endtask

    task automatic run_random(input int unsigned count);
        for (int n = 0; n < count; n++) begin
            if (take_bits(2) == 16'd0) begin
                @(negedge clock);
            end
            send_inst(random_inst());
        end
    endtask

    // r2 = r2 * r1 over and over, each MUL waits on the one before
    task automatic run_mul_burst();
        send_inst(inst_t'{OP_ADDI, 4'd1, 4'd0, 4'd3});
        send_inst(inst_t'{OP_ADDI, 4'd2, 4'd0, 4'd5});
        stall_cycles = 0;
        for (int n = 0; n < BURST_LEN; n++) begin
            send_inst(inst_t'{OP_MUL, 4'd2, 4'd2, 4'd1});
        end
        assert (stall_cycles != 0) else abort_run("inst_ready_o never dropped in the MUL burst");
    endtask

    always @(negedge clock) begin : check_commits
        expect_t head;
        if (!reset && commit_o.valid) begin
            assert (expected_q.size() != 0)
                else abort_run("commit seen with no accepted instruction outstanding");
            head = expected_q.pop_front();
            assert (commit_o.rd_wen == head.rd_wen)
                else value_mismatch("commit_o.rd_wen", commit_o.rd_wen, head.rd_wen);
            assert (commit_o.rd_arch == head.rd_arch)
                else value_mismatch("commit_o.rd_arch", commit_o.rd_arch, head.rd_arch);
            assert (!head.rd_wen || commit_o.value == head.value)
                else value_mismatch("commit_o.value", commit_o.value, head.value);
            assert (!head.rd_wen || commit_o.old_prf == head.old_prf)
                else value_mismatch("commit_o.old_prf", commit_o.old_prf, head.old_prf);
            // Retired mapping goes back to the tail of the free tag FIFO
            if (head.rd_wen) begin
                free_model_q.push_back(head.old_prf);
            end
        end
    end

    always @(negedge clock) begin
        assert (UUT.u_assert.fail_count == 0)
            else abort_run("a protocol assertion on ooo_backend failed");
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        reset        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        lfsr_q       = 16'd54;
        stall_cycles = 0;
        cycle_count  = 0;
        for (int r = 0; r < 16; r++) begin
            arch_regs[r] = '0;
            rat_model[r] = 5'(r);
        end
        for (int p = 16; p < 32; p++) begin
            free_model_q.push_back(5'(p));
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        run_random(RANDOM_COUNT / 2);
        run_mul_burst();
        run_random(RANDOM_COUNT - RANDOM_COUNT / 2);

        // Drain whatever is still in flight
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
        // A duplicated commit would still show up here
        repeat (QUIET_CYCLES) @(negedge clock);
        if (UUT.u_assert.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

`default_nettype wire

// ==== ooo_backend.f ====
verilog/isa_pkg.sv
verilog/uarch_pkg.sv
verilog/free_list.sv
verilog/rename_decode.sv
verilog/exec_unit.sv
verilog/rob.sv
verilog/ooo_backend.sv
tb/tb_clock_gen.sv
tb/ooo_backend_assert.sv
tb/ooo_backend_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_backend

sources:
  - verilog/isa_pkg.sv
  - verilog/uarch_pkg.sv
  - verilog/free_list.sv
  - verilog/rename_decode.sv
  - verilog/exec_unit.sv
  - verilog/rob.sv
  - verilog/ooo_backend.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/ooo_backend_assert.sv
      - tb/ooo_backend_tb.sv
